// File: verilog/cache_pkg.sv
// Shared types for the cache directory: op codes, MESI encoding, address/command/line/result structs
package cache_pkg;

    // Address field widths for a 32-bit byte address
    localparam int TAG_W    = 22;
    localparam int INDEX_W  = 4;
    localparam int OFFSET_W = 6;
    localparam int SETS     = 1 << INDEX_W;   // 16 sets per cache

    // Trace operation codes (print command 9 not handled)
    typedef enum logic [3:0] {
        OP_DREAD     = 4'd0,   // Data read
        OP_DWRITE    = 4'd1,   // Data write
        OP_IFETCH    = 4'd2,   // Instruction fetch
        OP_SNOOP_INV = 4'd3,   // Invalidate from another cache
        OP_SNOOP_RD  = 4'd4,   // Read seen from another cache
        OP_CLEAR     = 4'd8    // Reset both directories
    } op_e;

    // Line state, I must stay zero so a cleared line reads invalid
    typedef enum logic [1:0] {
        MESI_I = 2'd0,
        MESI_S = 2'd1,
        MESI_E = 2'd2,
        MESI_M = 2'd3
    } mesi_e;

    // Byte address split into cache fields
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } addr_t;

    // One trace command, 44 bits
    typedef struct packed {
        op_e        op;
        addr_t      addr;
        logic [7:0] pid;   // Processor id, carried but unused by the directory
    } command_t;

    // Directory entry for one way, 27 bits
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        mesi_e            mesi;
        logic [2:0]       lru;   // 0 = most recent, WAYS-1 = oldest
    } cache_line_t;

    // Per-command report
    typedef struct packed {
        logic       hit;
        logic [2:0] way;
        mesi_e      mesi;        // State of the way after the command
        logic       writeback;   // Modified line leaves the cache
    } result_t;

endpackage

// File: verilog/tag_store.sv
// Tag/state/age storage for one cache, one full set per index, registered read and one write port
`timescale 1ns/100ps

module tag_store #(
    parameter int WAYS = 8
) (
    input  logic                                      clk,
    input  logic                                      rd_en_i,
    input  logic                                      wr_en_i,
    input  logic [cache_pkg::INDEX_W-1:0]             rd_index_i,
    input  logic [cache_pkg::INDEX_W-1:0]             wr_index_i,
    input  cache_pkg::cache_line_t [WAYS-1:0]         set_d_i,
    output cache_pkg::cache_line_t [WAYS-1:0]         set_q_o
);

    // Whole set is one word, so a single access updates all ways and ages together
    cache_pkg::cache_line_t [WAYS-1:0] mem [cache_pkg::SETS];

    cache_pkg::cache_line_t [WAYS-1:0] set_q;   // Read register
    logic                              fwd;     // Write to the index being read

    assign fwd = wr_en_i && (wr_index_i == rd_index_i);

    // Synchronous write
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_index_i] <= set_d_i;
        end
    end

    // Registered read
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            if (fwd) begin
                set_q <= set_d_i;   // Same-cycle write wins, read sees new data
            end else begin
                set_q <= mem[rd_index_i];
            end
        end
    end

    assign set_q_o = set_q;   // Held until the next read

endmodule

// File: verilog/way_lookup.sv
// Tag compare, hit-way encoder and miss victim selection for one cache
`timescale 1ns/100ps

module way_lookup #(
    parameter int WAYS = 8
) (
    input  cache_pkg::cache_line_t [WAYS-1:0]   set_i,
    input  logic [cache_pkg::TAG_W-1:0]         tag_i,
    output logic                                hit_o,
    output logic [2:0]                          hit_way_o,
    output logic [2:0]                          victim_way_o
);

    logic [WAYS-1:0] match;     // Valid way with equal tag
    logic [WAYS-1:0] invalid;   // Way free for install
    logic [2:0]      hit_way;
    logic [2:0]      first_inv; // Lowest invalid way
    logic [2:0]      oldest;    // Way whose age is WAYS-1

    // Per-way compare
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            invalid[w] = (set_i[w].mesi == cache_pkg::MESI_I);
            match[w]   = !invalid[w] && (set_i[w].tag == tag_i);
        end
    end

    // Encode the hit, only one bit can be set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (match[w]) begin
                hit_way = 3'(w);
            end
        end
    end

    // Victim candidates
    always_comb begin
        first_inv = '0;
        oldest    = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (invalid[w]) begin
                first_inv = 3'(w);   // Downward scan leaves the lowest one
            end
        end
        for (int w = 0; w < WAYS; w++) begin
            if (set_i[w].lru == 3'(WAYS - 1)) begin
                oldest = 3'(w);
            end
        end
    end

    assign hit_o        = |match;
    assign hit_way_o    = hit_way;
    assign victim_way_o = (|invalid) ? first_inv : oldest;   // Free way before LRU eviction

    // Duplicate tags in a set would mean an install skipped the lookup
    always_comb begin
        if (!$isunknown(match)) begin
            assert final ($onehot0(match))
                else $error("way_lookup: more than one way hit, match=%b", match);
        end
    end

endmodule

// File: verilog/set_update.sv
// Next-set builder: LRU ageing, line install, MESI transitions and the per-command report
`timescale 1ns/100ps

module set_update #(
    parameter int WAYS = 8
) (
    input  logic                                clear_i,   // Emit the reset line pattern
    input  cache_pkg::cache_line_t [WAYS-1:0]   set_i,
    input  cache_pkg::op_e                      op_i,
    input  logic [cache_pkg::TAG_W-1:0]         tag_i,
    input  logic                                hit_i,
    input  logic [2:0]                          hit_way_i,
    input  logic [2:0]                          victim_way_i,
    output cache_pkg::cache_line_t [WAYS-1:0]   set_d_o,
    output cache_pkg::result_t                  result_o
);

    localparam int         WAY_W    = (WAYS > 1) ? $clog2(WAYS) : 1;
    localparam logic [7:0] ALL_AGES = 8'((1 << WAYS) - 1);   // Every age 0..WAYS-1 present

    logic [WAY_W-1:0]       sel_way;    // Hit way, else victim
    cache_pkg::cache_line_t sel_line;
    logic [2:0]             old_age;
    logic                   touch;      // Make sel_way most recent
    logic                   install;    // New tag goes into the victim
    logic                   write_line; // Tag/state of sel_way change
    logic                   wb;
    cache_pkg::mesi_e       new_mesi;
    logic [7:0]             ages_in;
    logic [7:0]             ages_out;

    assign sel_way  = hit_i ? hit_way_i[WAY_W-1:0] : victim_way_i[WAY_W-1:0];
    assign sel_line = set_i[sel_way];
    assign old_age  = sel_line.lru;

    // Per-op actions
    always_comb begin
        touch      = 1'b0;
        install    = 1'b0;
        write_line = 1'b0;
        wb         = 1'b0;
        new_mesi   = sel_line.mesi;
        case (op_i)
            cache_pkg::OP_DREAD, cache_pkg::OP_IFETCH: begin
                touch      = 1'b1;
                write_line = 1'b1;
                install    = !hit_i;
                if (!hit_i) begin
                    new_mesi = cache_pkg::MESI_E;   // Fill is exclusive, no other caches modelled
                end
            end
            cache_pkg::OP_DWRITE: begin
                touch      = 1'b1;
                write_line = 1'b1;
                install    = !hit_i;
                new_mesi   = cache_pkg::MESI_M;
            end
            cache_pkg::OP_SNOOP_INV: begin
                if (hit_i) begin
                    write_line = 1'b1;   // Ages left alone
                    new_mesi   = cache_pkg::MESI_I;
                    wb         = (sel_line.mesi == cache_pkg::MESI_M);
                end
            end
            cache_pkg::OP_SNOOP_RD: begin
                if (hit_i && (sel_line.mesi == cache_pkg::MESI_M ||
                              sel_line.mesi == cache_pkg::MESI_E)) begin
                    write_line = 1'b1;
                    new_mesi   = cache_pkg::MESI_S;
                    wb         = (sel_line.mesi == cache_pkg::MESI_M);
                end
            end
            default: ;   // Unknown op leaves the set as read
        endcase
        if (install && sel_line.mesi == cache_pkg::MESI_M) begin
            wb = 1'b1;   // Dirty victim evicted
        end
    end

    // New set contents
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            set_d_o[w] = set_i[w];
            if (clear_i) begin
                set_d_o[w].tag  = '0;
                set_d_o[w].mesi = cache_pkg::MESI_I;
                set_d_o[w].lru  = 3'(w);   // Ages start as the way number
            end else begin
                if (touch) begin
                    if (WAY_W'(w) == sel_way) begin
                        set_d_o[w].lru = '0;
                    end else if (set_i[w].lru < old_age) begin
                        set_d_o[w].lru = set_i[w].lru + 3'd1;   // Younger ways age by one
                    end
                end
                if (write_line && WAY_W'(w) == sel_way) begin
                    set_d_o[w].tag  = tag_i;
                    set_d_o[w].mesi = new_mesi;
                end
            end
        end
    end

    // Report, way and state only when a line was found or placed
    always_comb begin
        result_o = '0;
        if (!clear_i) begin
            result_o.hit       = hit_i;
            result_o.writeback = wb;
            if (hit_i || install) begin
                result_o.way  = 3'(sel_way);
                result_o.mesi = new_mesi;
            end
        end
    end

    // Age sets seen before and after the update
    always_comb begin
        ages_in  = '0;
        ages_out = '0;
        for (int w = 0; w < WAYS; w++) begin
            ages_in[set_i[w].lru]    = 1'b1;
            ages_out[set_d_o[w].lru] = 1'b1;
        end
    end

    // LRU ordering survives every update
    always_comb begin
        if (!$isunknown({set_i, set_d_o})) begin
            assert final (ages_in != ALL_AGES || ages_out == ALL_AGES)
                else $error("set_update: ages lost permutation, in=%b out=%b", ages_in, ages_out);
        end
    end

endmodule

// File: verilog/cache_ctrl.sv
// Command sequencer: accept, set read, update/write, clear walk, and result select
`timescale 1ns/100ps

module cache_ctrl (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              cmd_valid_i,
    input  cache_pkg::command_t               cmd_i,
    input  cache_pkg::result_t                d_result_i,
    input  cache_pkg::result_t                i_result_i,
    output logic                              ready_o,
    output logic                              done_o,
    output logic                              rd_en_o,
    output logic                              d_wr_en_o,
    output logic                              i_wr_en_o,
    output logic [cache_pkg::INDEX_W-1:0]     rd_index_o,
    output logic [cache_pkg::INDEX_W-1:0]     wr_index_o,
    output cache_pkg::command_t               cmd_q_o,
    output logic                              clear_o,
    output cache_pkg::result_t                result_o
);

    typedef enum logic [1:0] {
        ST_CLEAR,    // Walking all indices, writing reset lines
        ST_IDLE,     // Waiting for a strobe
        ST_READ,     // Set read in flight
        ST_UPDATE    // Lookup, write back, report
    } state_e;

    state_e                        state;
    logic [cache_pkg::INDEX_W-1:0] clr_idx;     // Walk position
    logic                          clr_report;  // Walk came from OP_CLEAR, not reset
    logic                          done_q;
    cache_pkg::command_t           cmd_q;       // Accepted command
    logic                          accept;
    logic                          is_ifetch;

    assign accept    = cmd_valid_i && (state == ST_IDLE);
    assign is_ifetch = (cmd_q.op == cache_pkg::OP_IFETCH);

    // FSM and walk counter
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state      <= ST_CLEAR;   // Reset runs the same walk
            clr_idx    <= '0;
            clr_report <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ST_CLEAR: begin
                    clr_idx <= clr_idx + 1'b1;
                    if (clr_idx == cache_pkg::INDEX_W'(cache_pkg::SETS - 1)) begin
                        state      <= ST_IDLE;
                        done_q     <= clr_report;   // Silent after reset
                        clr_report <= 1'b0;
                    end
                end
                ST_IDLE: begin
                    if (cmd_valid_i) begin
                        if (cmd_i.op == cache_pkg::OP_CLEAR) begin
                            state      <= ST_CLEAR;
                            clr_idx    <= '0;
                            clr_report <= 1'b1;
                        end else begin
                            state <= ST_READ;
                        end
                    end
                end
                ST_READ: begin
                    state  <= ST_UPDATE;
                    done_q <= 1'b1;   // High for the update cycle
                end
                default: state <= ST_IDLE;   // ST_UPDATE
            endcase
        end
    end

    // Command hold
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd_i;
        end
    end

    assign ready_o    = (state == ST_IDLE);
    assign done_o     = done_q;
    assign clear_o    = (state == ST_CLEAR);
    assign rd_en_o    = (state == ST_READ);
    assign rd_index_o = cmd_q.addr.index;
    assign wr_index_o = clear_o ? clr_idx : cmd_q.addr.index;
    assign cmd_q_o    = cmd_q;

    // Only the targeted cache is written, both during a walk
    assign d_wr_en_o = clear_o || (state == ST_UPDATE && !is_ifetch);
    assign i_wr_en_o = clear_o || (state == ST_UPDATE && is_ifetch);

    // Fetches report from the instruction cache, all else from data
    assign result_o = (state != ST_UPDATE) ? '0 :
                      is_ifetch            ? i_result_i : d_result_i;

    // A strobe while busy would be dropped
    a_no_busy_strobe: assert property (@(posedge clk) disable iff (rst_i)
        cmd_valid_i |-> ready_o)
        else $error("cache_ctrl: command strobe while not ready");

    // Every report closes a busy period
    a_done_after_busy: assert property (@(posedge clk) disable iff (rst_i)
        done_o |-> !$past(ready_o))
        else $error("cache_ctrl: done without a preceding busy cycle");

endmodule

// File: verilog/cache_top.sv
// Top level: controller plus 8-way data and 4-way instruction directory datapaths
`timescale 1ns/100ps

module cache_top #(
    parameter int D_WAYS = 8,
    parameter int I_WAYS = 4
) (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  cmd_valid_i,
    input  cache_pkg::command_t   cmd_i,
    output logic                  ready_o,
    output logic                  done_o,
    output cache_pkg::result_t    result_o
);

    logic                              rd_en;
    logic                              d_wr_en;
    logic                              i_wr_en;
    logic [cache_pkg::INDEX_W-1:0]     rd_index;
    logic [cache_pkg::INDEX_W-1:0]     wr_index;
    cache_pkg::command_t               cmd_q;
    logic                              clear;

    // Data cache path
    cache_pkg::cache_line_t [D_WAYS-1:0] d_set_q;
    cache_pkg::cache_line_t [D_WAYS-1:0] d_set_d;
    logic                                d_hit;
    logic [2:0]                          d_hit_way;
    logic [2:0]                          d_victim;
    cache_pkg::result_t                  d_result;

    // Instruction cache path
    cache_pkg::cache_line_t [I_WAYS-1:0] i_set_q;
    cache_pkg::cache_line_t [I_WAYS-1:0] i_set_d;
    logic                                i_hit;
    logic [2:0]                          i_hit_way;
    logic [2:0]                          i_victim;
    cache_pkg::result_t                  i_result;

    cache_ctrl ctrl_i (
        .clk, .rst_i, .cmd_valid_i, .cmd_i,
        .d_result_i(d_result), .i_result_i(i_result),
        .ready_o, .done_o,
        .rd_en_o(rd_en), .d_wr_en_o(d_wr_en), .i_wr_en_o(i_wr_en),
        .rd_index_o(rd_index), .wr_index_o(wr_index),
        .cmd_q_o(cmd_q), .clear_o(clear), .result_o
    );

    tag_store #(.WAYS(D_WAYS)) d_store_i (
        .clk, .rd_en_i(rd_en), .wr_en_i(d_wr_en),
        .rd_index_i(rd_index), .wr_index_i(wr_index),
        .set_d_i(d_set_d), .set_q_o(d_set_q)
    );

    way_lookup #(.WAYS(D_WAYS)) d_lookup_i (
        .set_i(d_set_q), .tag_i(cmd_q.addr.tag),
        .hit_o(d_hit), .hit_way_o(d_hit_way), .victim_way_o(d_victim)
    );

    set_update #(.WAYS(D_WAYS)) d_update_i (
        .clear_i(clear), .set_i(d_set_q), .op_i(cmd_q.op), .tag_i(cmd_q.addr.tag),
        .hit_i(d_hit), .hit_way_i(d_hit_way), .victim_way_i(d_victim),
        .set_d_o(d_set_d), .result_o(d_result)
    );

    tag_store #(.WAYS(I_WAYS)) i_store_i (
        .clk, .rd_en_i(rd_en), .wr_en_i(i_wr_en),
        .rd_index_i(rd_index), .wr_index_i(wr_index),
        .set_d_i(i_set_d), .set_q_o(i_set_q)
    );

    way_lookup #(.WAYS(I_WAYS)) i_lookup_i (
        .set_i(i_set_q), .tag_i(cmd_q.addr.tag),
        .hit_o(i_hit), .hit_way_o(i_hit_way), .victim_way_o(i_victim)
    );

    set_update #(.WAYS(I_WAYS)) i_update_i (
        .clear_i(clear), .set_i(i_set_q), .op_i(cmd_q.op), .tag_i(cmd_q.addr.tag),
        .hit_i(i_hit), .hit_way_i(i_hit_way), .victim_way_i(i_victim),
        .set_d_o(i_set_d), .result_o(i_result)
    );

endmodule

// File: tb/cache_tb.sv
// Cache directory testbench: MESI/LRU reference model, directed and random commands, result assertions
`timescale 1ns/100ps

module cache_tb;

    localparam int TIMEOUT_CYCLES = 40;   // Longest wait is the 17-cycle clear walk
    localparam int N_RANDOM       = 300;

    logic                clk;
    logic                rst_i;
    logic                cmd_valid_i;
    cache_pkg::command_t cmd_i;
    logic                ready_o;
    logic                done_o;
    cache_pkg::result_t  result_o;

    // Reference directory, cache 0 is data, cache 1 is instruction (ways 0..3 only)
    logic [cache_pkg::TAG_W-1:0] m_tag  [2][cache_pkg::SETS][8];
    cache_pkg::mesi_e            m_mesi [2][cache_pkg::SETS][8];
    int                          m_lru  [2][cache_pkg::SETS][8];

    cache_pkg::result_t exp_result;      // Report expected at the next done_o
    logic               accept_op;       // Strobe taken for a two-cycle command
    logic               accept_clear;    // Strobe taken for OP_CLEAR
    int                 err_count  = 0;
    int                 cmd_count  = 0;
    int                 done_count = 0;

    cache_top dut_i (
        .clk, .rst_i, .cmd_valid_i, .cmd_i,
        .ready_o, .done_o, .result_o
    );

    always #2 clk = ~clk;   // 4 ns period

    assign accept_op    = cmd_valid_i && ready_o && (cmd_i.op != cache_pkg::OP_CLEAR);
    assign accept_clear = cmd_valid_i && ready_o && (cmd_i.op == cache_pkg::OP_CLEAR);

    always @(posedge clk) begin
        if (!rst_i && done_o) begin
            done_count <= done_count + 1;
        end
    end

    task automatic report_failure(input string what);
        err_count++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic report_field(input string name, input int expected, input int actual);
        err_count++;
        $display("mismatch at %0t: %s expected=%0d actual=%0d", $time, name, expected, actual);
    endtask

    // Report fields against the model, one check per field
    a_hit: assert property (@(posedge clk) disable iff (rst_i)
        done_o |-> result_o.hit == exp_result.hit)
        else report_field("result_o.hit", int'($sampled(exp_result.hit)),
                          int'($sampled(result_o.hit)));
    a_way: assert property (@(posedge clk) disable iff (rst_i)
        done_o |-> result_o.way == exp_result.way)
        else report_field("result_o.way", int'($sampled(exp_result.way)),
                          int'($sampled(result_o.way)));
    a_mesi: assert property (@(posedge clk) disable iff (rst_i)
        done_o |-> result_o.mesi == exp_result.mesi)
        else report_field("result_o.mesi", int'($sampled(exp_result.mesi)),
                          int'($sampled(result_o.mesi)));
    a_wb: assert property (@(posedge clk) disable iff (rst_i)
        done_o |-> result_o.writeback == exp_result.writeback)
        else report_field("result_o.writeback", int'($sampled(exp_result.writeback)),
                          int'($sampled(result_o.writeback)));

    // Report two cycles after an accepted command, SETS+1 after a clear, and at no other time
    a_done_latency: assert property (@(posedge clk) disable iff (rst_i)
        $past(accept_op, 2) |-> done_o)
        else report_failure("done_o missing two cycles after an accepted command");
    a_clear_latency: assert property (@(posedge clk) disable iff (rst_i)
        $past(accept_clear, cache_pkg::SETS + 1) |-> done_o)
        else report_failure("done_o missing at the end of the clear walk");
    a_done_source: assert property (@(posedge clk) disable iff (rst_i)
        done_o |-> ($past(accept_op, 2) || $past(accept_clear, cache_pkg::SETS + 1)))
        else report_failure("done_o without a matching accepted command");

    // Busy through read and update, free again once the report has gone
    a_ready_busy: assert property (@(posedge clk) disable iff (rst_i)
        ($past(accept_op) || $past(accept_op, 2)) |-> !ready_o)
        else report_failure("ready_o high while a command is in flight");
    a_ready_back: assert property (@(posedge clk) disable iff (rst_i)
        $past(accept_op, 3) |-> ready_o)
        else report_failure("ready_o not back after the report cycle");

    task automatic clear_model();
        for (int c = 0; c < 2; c++) begin
            for (int s = 0; s < cache_pkg::SETS; s++) begin
                for (int w = 0; w < 8; w++) begin
                    m_tag[c][s][w]  = '0;
                    m_mesi[c][s][w] = cache_pkg::MESI_I;
                    m_lru[c][s][w]  = w;   // Age equals way number
                end
            end
        end
    endtask

    // One command applied to cache c of the model, with the report it should give
    task automatic model_access(input int c, input cache_pkg::op_e op,
                                input logic [cache_pkg::TAG_W-1:0] tag, input int s,
                                output cache_pkg::result_t r);
        int               ways;
        int               sel;
        int               old_age;
        logic             hit;
        cache_pkg::mesi_e old_m;
        ways = (c == 0) ? 8 : 4;
        hit  = 1'b0;
        sel  = -1;
        for (int w = 0; w < ways; w++) begin
            if (m_mesi[c][s][w] != cache_pkg::MESI_I && m_tag[c][s][w] == tag) begin
                hit = 1'b1;
                sel = w;
            end
        end
        for (int w = 0; w < ways; w++) begin
            if (sel < 0 && m_mesi[c][s][w] == cache_pkg::MESI_I) begin
                sel = w;   // Lowest free way
            end
        end
        for (int w = 0; w < ways; w++) begin
            if (sel < 0 && m_lru[c][s][w] == ways - 1) begin
                sel = w;   // Full set, oldest way goes
            end
        end
        old_m   = m_mesi[c][s][sel];
        old_age = m_lru[c][s][sel];
        r       = '0;
        r.hit   = hit;
        if (op == cache_pkg::OP_DREAD || op == cache_pkg::OP_IFETCH ||
            op == cache_pkg::OP_DWRITE) begin
            for (int w = 0; w < ways; w++) begin
                if (m_lru[c][s][w] < old_age) begin
                    m_lru[c][s][w]++;
                end
            end
            m_lru[c][s][sel] = 0;
            m_tag[c][s][sel] = tag;
            if (op == cache_pkg::OP_DWRITE) begin
                m_mesi[c][s][sel] = cache_pkg::MESI_M;
            end else if (!hit) begin
                m_mesi[c][s][sel] = cache_pkg::MESI_E;   // Read fill
            end
            r.writeback = !hit && (old_m == cache_pkg::MESI_M);   // Dirty victim
            r.way       = 3'(sel);
            r.mesi      = m_mesi[c][s][sel];
        end else if (hit) begin
            // Snoops leave ages alone
            if (op == cache_pkg::OP_SNOOP_INV) begin
                r.writeback       = (old_m == cache_pkg::MESI_M);
                m_mesi[c][s][sel] = cache_pkg::MESI_I;
            end else if (old_m == cache_pkg::MESI_M || old_m == cache_pkg::MESI_E) begin
                r.writeback       = (old_m == cache_pkg::MESI_M);
                m_mesi[c][s][sel] = cache_pkg::MESI_S;
            end
            r.way  = 3'(sel);
            r.mesi = m_mesi[c][s][sel];
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready_o && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #0.5;
            n++;
        end
        if (!ready_o) begin
            report_failure("timed out waiting for ready_o");
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done_o && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #0.5;
            n++;
        end
        if (!done_o) begin
            report_failure("timed out waiting for done_o");
        end
    endtask

    // Model first, then strobe for one cycle and wait for the report
    task automatic run_cmd(input cache_pkg::op_e op, input logic [cache_pkg::TAG_W-1:0] tag,
                           input int s);
        cache_pkg::result_t  r;
        cache_pkg::command_t c;
        wait_ready();
        c.op          = op;
        c.addr.tag    = tag;
        c.addr.index  = 4'(s);
        c.addr.offset = 6'($urandom);   // Offset and pid do not affect the directory
        c.pid         = 8'($urandom);
        if (op == cache_pkg::OP_CLEAR) begin
            clear_model();
            r = '0;
        end else if (op == cache_pkg::OP_IFETCH) begin
            model_access(1, op, tag, s, r);
        end else begin
            model_access(0, op, tag, s, r);
        end
        exp_result  = r;
        cmd_i       = c;
        cmd_valid_i = 1'b1;
        cmd_count++;
        @(posedge clk);
        #0.5;
        cmd_valid_i = 1'b0;
        wait_done();
        @(posedge clk);   // Report sampled against this expectation
        #0.5;
    endtask

    function automatic cache_pkg::op_e pick_op(input int r);
        case (r)
            0, 1, 2:  return cache_pkg::OP_DREAD;
            3, 4:     return cache_pkg::OP_DWRITE;
            5, 6:     return cache_pkg::OP_IFETCH;
            7:        return cache_pkg::OP_SNOOP_INV;
            default:  return cache_pkg::OP_SNOOP_RD;
        endcase
    endfunction

    initial begin
        clk           = 1'b0;
        rst_i         = 1'b1;
        cmd_valid_i   = 1'b0;
        cmd_i         = '0;
        exp_result    = '0;
        void'($urandom(32'h8c2f33cb));
        clear_model();
        repeat (8) @(posedge clk);
        #0.5;
        rst_i = 1'b0;

        // Cold miss, read hit, then write hit to M
        run_cmd(cache_pkg::OP_DREAD, 22'h1a2b3, 3);
        run_cmd(cache_pkg::OP_DREAD, 22'h1a2b3, 3);
        run_cmd(cache_pkg::OP_DWRITE, 22'h1a2b3, 3);

        // Ten tags into one set, evicting an M line and then an E line
        for (int i = 0; i < 10; i++) begin
            run_cmd((i % 3 == 0) ? cache_pkg::OP_DWRITE : cache_pkg::OP_DREAD, 22'(32'h200 + i), 5);
        end
        for (int i = 0; i < 6; i++) begin
            run_cmd(cache_pkg::OP_IFETCH, 22'(32'h200 + i), 5);   // 4 ways, last two evict
        end

        // Fetched line is absent from the data cache
        run_cmd(cache_pkg::OP_IFETCH, 22'h0beef, 7);
        run_cmd(cache_pkg::OP_DREAD, 22'h0beef, 7);

        // Snoops on M, S and E lines and on a miss
        run_cmd(cache_pkg::OP_DWRITE, 22'h3c0, 9);
        run_cmd(cache_pkg::OP_SNOOP_RD, 22'h3c0, 9);
        run_cmd(cache_pkg::OP_SNOOP_RD, 22'h3c0, 9);
        run_cmd(cache_pkg::OP_SNOOP_INV, 22'h3c0, 9);
        run_cmd(cache_pkg::OP_SNOOP_INV, 22'h3c0, 9);
        run_cmd(cache_pkg::OP_DREAD, 22'h3c1, 9);
        run_cmd(cache_pkg::OP_SNOOP_INV, 22'h3c1, 9);
        run_cmd(cache_pkg::OP_DWRITE, 22'h3c2, 9);
        run_cmd(cache_pkg::OP_SNOOP_INV, 22'h3c2, 9);

        // Ten tags over two sets keep both caches evicting
        for (int i = 0; i < N_RANDOM; i++) begin
            run_cmd(pick_op($urandom % 10), 22'(32'h100 + $urandom % 10), 10 + $urandom % 2);
        end

        // Clear, then everything misses
        run_cmd(cache_pkg::OP_CLEAR, 22'h0, 0);
        run_cmd(cache_pkg::OP_DREAD, 22'h1a2b3, 3);
        run_cmd(cache_pkg::OP_IFETCH, 22'h200, 5);
        run_cmd(cache_pkg::OP_SNOOP_RD, 22'h100, 10);

        repeat (4) @(posedge clk);
        if (done_count != cmd_count) begin
            report_failure("number of done_o pulses differs from commands issued");
        end
        $display("commands=%0d reports=%0d errors=%0d", cmd_count, done_count, err_count);
        if (err_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: project.f
verilog/cache_pkg.sv
verilog/tag_store.sv
verilog/way_lookup.sv
verilog/set_update.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
tb/cache_tb.sv

// File: run.sh
#!/bin/sh
# Build the cache directory testbench with Verilator, run it, and pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cache_tb -f project.f -o cache_sim &&
    ./obj_dir/cache_sim | tee /dev/stderr | grep -q "Regression passed" &&
    echo "run.sh: simulation passed" ||
    { echo "run.sh: simulation failed"; exit 1; }
